/* source/parser_settings.svh */
`ifndef PARSER_SETTINGS_SVH
`define PARSER_SETTINGS_SVH

// stream and header window
`define PARSER_DATA_W       512
`define PARSER_HDR_W        1024
`define PARSER_LOOKUP_LSB   120

// parse-action table
`define PARSER_NUM_ACT      8
`define PARSER_ACT_W        16
`define PARSER_ENTRY_W      128
`define PARSER_TBL_AW       4

// action layout: valid, kind, container index, byte offset
`define PARSER_ACT_VALID_BIT 0
`define PARSER_ACT_KIND_LSB  1
`define PARSER_ACT_KIND_W    2
`define PARSER_ACT_IDX_LSB   3
`define PARSER_ACT_IDX_W     3
`define PARSER_ACT_OFF_LSB   6
`define PARSER_ACT_OFF_W     7

// containers and PHV
`define PARSER_NUM_CONT     8
`define PARSER_VAL_W        48
`define PARSER_PHV_W        768

// control stream fields
`define CTRL_MODID_LSB      368
`define CTRL_MODID_W        8
`define CTRL_FLAG_LSB       320
`define CTRL_FLAG_W         16
`define CTRL_INDEX_LSB      384
`define CTRL_WRITE_FLAG     16'hF1F2

`endif

/* source/parser_pkg.sv */
package parser_pkg;

    // container size named by a parse action
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_2B   = 2'd1,
        KIND_4B   = 2'd2,
        KIND_6B   = 2'd3
    } cont_kind_e;

    // datapath sequencing, one step per cycle after the first beat
    typedef enum logic [1:0] {
        PS_IDLE        = 2'd0,
        PS_WAIT_HEADER = 2'd1,
        PS_EXTRACT     = 2'd2,
        PS_EMIT        = 2'd3
    } parse_state_e;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

    // idle forwards beats, write consumes a matching table-write packet
    typedef enum logic {
        CFG_IDLE  = 1'b0,
        CFG_WRITE = 1'b1
    } cfg_state_e;

endpackage

/* source/parse_fsm.sv */
`timescale 1ns/1ps

module parse_fsm (
    input  logic axis_clk,
    input  logic aresetn,
    input  logic s_axis_tvalid_i,
    output logic start_o,
    output logic second_beat_o,
    output logic extract_en_o,
    output logic emit_o,
    output logic phv_valid_o
);

    parser_pkg::parse_state_e state;
    parser_pkg::parse_state_e state_nxt;
    logic tvalid_q;

    // first beat is a rising edge of tvalid
    assign start_o       = s_axis_tvalid_i & ~tvalid_q;
    assign second_beat_o = (state == parser_pkg::PS_WAIT_HEADER);
    assign extract_en_o  = (state == parser_pkg::PS_EXTRACT);
    assign emit_o        = (state == parser_pkg::PS_EMIT);

    always_comb begin
        state_nxt = state;
        case (state)
            parser_pkg::PS_IDLE: begin
                if (start_o) begin
                    state_nxt = parser_pkg::PS_WAIT_HEADER;
                end
            end
            // second beat follows the first without a gap
            parser_pkg::PS_WAIT_HEADER: state_nxt = parser_pkg::PS_EXTRACT;
            parser_pkg::PS_EXTRACT:     state_nxt = parser_pkg::PS_EMIT;
            parser_pkg::PS_EMIT:        state_nxt = parser_pkg::PS_IDLE;
            default:                    state_nxt = parser_pkg::PS_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= parser_pkg::PS_IDLE;
            tvalid_q    <= 1'b0;
            phv_valid_o <= 1'b0;
        end else begin
            state       <= state_nxt;
            tvalid_q    <= s_axis_tvalid_i;
            // containers are written on the emit edge
            phv_valid_o <= emit_o;
        end
    end

endmodule

/* source/header_capture.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module header_capture (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  logic [`PARSER_DATA_W-1:0]   s_axis_tdata_i,
    input  logic                        s_axis_tvalid_i,
    input  logic                        start_i,
    input  logic                        second_beat_i,
    output logic [`PARSER_HDR_W-1:0]    hdr_window_o,
    output logic [`PARSER_TBL_AW-1:0]   lookup_addr_o
);

    localparam int UPPER_W = `PARSER_HDR_W - `PARSER_DATA_W;

    // first beat fills the low half, second beat the high half
    always_ff @(posedge axis_clk) begin
        if (start_i) begin
            hdr_window_o <= {{UPPER_W{1'b0}}, s_axis_tdata_i};
        end else if (second_beat_i && s_axis_tvalid_i) begin
            hdr_window_o[`PARSER_HDR_W-1 -: `PARSER_DATA_W] <= s_axis_tdata_i;
        end
    end

    // upper nibble of the VLAN ID byte selects the entry
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            lookup_addr_o <= '0;
        end else if (start_i) begin
            lookup_addr_o <= s_axis_tdata_i[`PARSER_LOOKUP_LSB +: `PARSER_TBL_AW];
        end
    end

endmodule

/* source/parse_action_table.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module parse_action_table (
    input  logic                        axis_clk,
    input  logic                        wr_en_i,
    input  logic [`PARSER_TBL_AW-1:0]   wr_addr_i,
    input  logic [`PARSER_ENTRY_W-1:0]  wr_data_i,
    input  logic [`PARSER_TBL_AW-1:0]   rd_addr_i,
    output logic [`PARSER_ENTRY_W-1:0]  rd_data_o
);

    localparam int DEPTH = 1 << `PARSER_TBL_AW;

    logic [`PARSER_ENTRY_W-1:0] mem [DEPTH];

    always_ff @(posedge axis_clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, entry stable one cycle after the address
    always_ff @(posedge axis_clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* source/field_extractor.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module field_extractor (
    input  logic                            axis_clk,
    input  logic                            aresetn,
    input  logic [`PARSER_HDR_W-1:0]        hdr_window_i,
    input  logic [`PARSER_ACT_W-1:0]        action_i,
    input  logic                            extract_en_i,
    output logic [`PARSER_VAL_W-1:0]        val_o,
    output parser_pkg::cont_kind_e          kind_o,
    output logic [`PARSER_ACT_IDX_W-1:0]    index_o
);

    localparam int EXT_W = `PARSER_HDR_W + `PARSER_VAL_W;

    logic [EXT_W-1:0]                window_ext;
    logic [`PARSER_ACT_OFF_W-1:0]    byte_off;
    logic [`PARSER_VAL_W-1:0]        raw;
    logic [`PARSER_VAL_W-1:0]        field;
    parser_pkg::cont_kind_e          kind_act;

    // zero pad so reads past byte 127 come back as zero
    assign window_ext = {{`PARSER_VAL_W{1'b0}}, hdr_window_i};
    assign byte_off   = action_i[`PARSER_ACT_OFF_LSB +: `PARSER_ACT_OFF_W];
    assign raw        = window_ext[{byte_off, 3'b000} +: `PARSER_VAL_W];

    assign kind_act = action_i[`PARSER_ACT_VALID_BIT]
                    ? parser_pkg::cont_kind_e'(action_i[`PARSER_ACT_KIND_LSB +: `PARSER_ACT_KIND_W])
                    : parser_pkg::KIND_NONE;

    always_comb begin
        case (kind_act)
            parser_pkg::KIND_2B: field = {32'b0, raw[15:0]};
            parser_pkg::KIND_4B: field = {16'b0, raw[31:0]};
            parser_pkg::KIND_6B: field = raw;
            default:             field = '0;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (extract_en_i) begin
            val_o   <= field;
            index_o <= action_i[`PARSER_ACT_IDX_LSB +: `PARSER_ACT_IDX_W];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            kind_o <= parser_pkg::KIND_NONE;
        end else if (extract_en_i) begin
            kind_o <= kind_act;
        end
    end

endmodule

/* source/phv_assembler.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module phv_assembler (
    input  logic                            axis_clk,
    input  logic                            aresetn,
    input  logic                            start_i,
    input  logic                            emit_i,
    input  logic [`PARSER_VAL_W-1:0]        val_i [`PARSER_NUM_ACT],
    input  parser_pkg::cont_kind_e          kind_i [`PARSER_NUM_ACT],
    input  logic [`PARSER_ACT_IDX_W-1:0]    index_i [`PARSER_NUM_ACT],
    output logic [`PARSER_PHV_W-1:0]        phv_o
);

    localparam int W2     = 16;
    localparam int W4     = 32;
    localparam int W6     = `PARSER_VAL_W;
    localparam int OFF_4B = `PARSER_NUM_CONT * W2;
    localparam int OFF_6B = `PARSER_NUM_CONT * (W2 + W4);

    logic [W2-1:0] cont_2b [`PARSER_NUM_CONT];
    logic [W4-1:0] cont_4b [`PARSER_NUM_CONT];
    logic [W6-1:0] cont_6b [`PARSER_NUM_CONT];

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int c = 0; c < `PARSER_NUM_CONT; c++) begin
                cont_2b[c] <= '0;
                cont_4b[c] <= '0;
                cont_6b[c] <= '0;
            end
        end else if (start_i) begin
            for (int c = 0; c < `PARSER_NUM_CONT; c++) begin
                cont_2b[c] <= '0;
                cont_4b[c] <= '0;
                cont_6b[c] <= '0;
            end
        end else if (emit_i) begin
            // later actions overwrite earlier ones on the same container
            for (int a = 0; a < `PARSER_NUM_ACT; a++) begin
                case (kind_i[a])
                    parser_pkg::KIND_2B: cont_2b[index_i[a]] <= val_i[a][W2-1:0];
                    parser_pkg::KIND_4B: cont_4b[index_i[a]] <= val_i[a][W4-1:0];
                    parser_pkg::KIND_6B: cont_6b[index_i[a]] <= val_i[a];
                    default: ;
                endcase
            end
        end
    end

    // big endian, widest containers on top, highest index first
    genvar c;
    generate
        for (c = 0; c < `PARSER_NUM_CONT; c++) begin : g_pack
            assign phv_o[OFF_6B + c*W6 +: W6] = {<<8{cont_6b[c]}};
            assign phv_o[OFF_4B + c*W4 +: W4] = {<<8{cont_4b[c]}};
            assign phv_o[c*W2 +: W2]          = {<<8{cont_2b[c]}};
        end
    endgenerate

endmodule

/* source/config_writer.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module config_writer #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  logic [`PARSER_DATA_W-1:0]   c_s_axis_tdata_i,
    input  logic                        c_s_axis_tvalid_i,
    input  logic                        c_s_axis_tlast_i,
    output logic [`PARSER_DATA_W-1:0]   c_m_axis_tdata_o,
    output logic                        c_m_axis_tvalid_o,
    output logic                        c_m_axis_tlast_o,
    output logic                        tbl_wr_en_o,
    output logic [`PARSER_TBL_AW-1:0]   tbl_wr_addr_o,
    output logic [`PARSER_ENTRY_W-1:0]  tbl_wr_data_o
);

    ctrl_pkg::cfg_state_e           state;
    logic [`CTRL_MODID_W-1:0]       mod_id;
    logic [`CTRL_FLAG_W-1:0]        ctrl_flag;
    logic [`PARSER_DATA_W-1:0]      tdata_swapped;
    logic                           match;

    assign mod_id    = c_s_axis_tdata_i[`CTRL_MODID_LSB +: `CTRL_MODID_W];
    assign ctrl_flag = c_s_axis_tdata_i[`CTRL_FLAG_LSB +: `CTRL_FLAG_W];
    assign match     = c_s_axis_tvalid_i && (mod_id[2:0] == PARSER_ID)
                    && (ctrl_flag == `CTRL_WRITE_FLAG);

    // byte 0 lands on top, so action 0 is {byte 0, byte 1}
    assign tdata_swapped = {<<8{c_s_axis_tdata_i}};
    assign tbl_wr_data_o = tdata_swapped[`PARSER_DATA_W-1 -: `PARSER_ENTRY_W];
    assign tbl_wr_en_o   = (state == ctrl_pkg::CFG_WRITE) && c_s_axis_tvalid_i;

    always_ff @(posedge axis_clk) begin
        c_m_axis_tdata_o <= c_s_axis_tdata_i;
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state             <= ctrl_pkg::CFG_IDLE;
            c_m_axis_tvalid_o <= 1'b0;
            c_m_axis_tlast_o  <= 1'b0;
            tbl_wr_addr_o     <= '0;
        end else begin
            case (state)
                ctrl_pkg::CFG_IDLE: begin
                    if (match) begin
                        // swallow the packet, entries follow from the next beat
                        c_m_axis_tvalid_o <= 1'b0;
                        c_m_axis_tlast_o  <= 1'b0;
                        tbl_wr_addr_o     <= c_s_axis_tdata_i[`CTRL_INDEX_LSB +: `PARSER_TBL_AW];
                        if (!c_s_axis_tlast_i) begin
                            state <= ctrl_pkg::CFG_WRITE;
                        end
                    end else begin
                        c_m_axis_tvalid_o <= c_s_axis_tvalid_i;
                        c_m_axis_tlast_o  <= c_s_axis_tlast_i;
                    end
                end
                ctrl_pkg::CFG_WRITE: begin
                    c_m_axis_tvalid_o <= 1'b0;
                    c_m_axis_tlast_o  <= 1'b0;
                    if (c_s_axis_tvalid_i) begin
                        tbl_wr_addr_o <= tbl_wr_addr_o + 1'b1;
                        if (c_s_axis_tlast_i) begin
                            state <= ctrl_pkg::CFG_IDLE;
                        end
                    end
                end
                default: state <= ctrl_pkg::CFG_IDLE;
            endcase
        end
    end

endmodule

/* source/parser_top.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module parser_top #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  logic [`PARSER_DATA_W-1:0]   s_axis_tdata_i,
    input  logic                        s_axis_tvalid_i,
    input  logic                        s_axis_tlast_i,
    output logic                        phv_valid_o,
    output logic [`PARSER_PHV_W-1:0]    phv_o,
    input  logic [`PARSER_DATA_W-1:0]   c_s_axis_tdata_i,
    input  logic                        c_s_axis_tvalid_i,
    input  logic                        c_s_axis_tlast_i,
    output logic [`PARSER_DATA_W-1:0]   c_m_axis_tdata_o,
    output logic                        c_m_axis_tvalid_o,
    output logic                        c_m_axis_tlast_o
);

    logic                           start;
    logic                           second_beat;
    logic                           extract_en;
    logic                           emit;
    logic [`PARSER_HDR_W-1:0]       hdr_window;
    logic [`PARSER_TBL_AW-1:0]      lookup_addr;
    logic [`PARSER_ENTRY_W-1:0]     entry;
    logic                           tbl_wr_en;
    logic [`PARSER_TBL_AW-1:0]      tbl_wr_addr;
    logic [`PARSER_ENTRY_W-1:0]     tbl_wr_data;
    logic [`PARSER_VAL_W-1:0]       ext_val [`PARSER_NUM_ACT];
    parser_pkg::cont_kind_e         ext_kind [`PARSER_NUM_ACT];
    logic [`PARSER_ACT_IDX_W-1:0]   ext_index [`PARSER_NUM_ACT];

    parse_fsm i_parse_fsm (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .start_o         (start),
        .second_beat_o   (second_beat),
        .extract_en_o    (extract_en),
        .emit_o          (emit),
        .phv_valid_o     (phv_valid_o)
    );

    header_capture i_header_capture (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .start_i         (start),
        .second_beat_i   (second_beat),
        .hdr_window_o    (hdr_window),
        .lookup_addr_o   (lookup_addr)
    );

    parse_action_table i_parse_action_table (
        .axis_clk  (axis_clk),
        .wr_en_i   (tbl_wr_en),
        .wr_addr_i (tbl_wr_addr),
        .wr_data_i (tbl_wr_data),
        .rd_addr_i (lookup_addr),
        .rd_data_o (entry)
    );

    // action 0 sits in the top bits of the entry
    genvar g;
    generate
        for (g = 0; g < `PARSER_NUM_ACT; g++) begin : g_ext
            field_extractor i_field_extractor (
                .axis_clk     (axis_clk),
                .aresetn      (aresetn),
                .hdr_window_i (hdr_window),
                .action_i     (entry[`PARSER_ENTRY_W-1-g*`PARSER_ACT_W -: `PARSER_ACT_W]),
                .extract_en_i (extract_en),
                .val_o        (ext_val[g]),
                .kind_o       (ext_kind[g]),
                .index_o      (ext_index[g])
            );
        end
    endgenerate

    phv_assembler i_phv_assembler (
        .axis_clk (axis_clk),
        .aresetn  (aresetn),
        .start_i  (start),
        .emit_i   (emit),
        .val_i    (ext_val),
        .kind_i   (ext_kind),
        .index_i  (ext_index),
        .phv_o    (phv_o)
    );

    config_writer #(
        .PARSER_ID (PARSER_ID)
    ) i_config_writer (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o),
        .tbl_wr_en_o       (tbl_wr_en),
        .tbl_wr_addr_o     (tbl_wr_addr),
        .tbl_wr_data_o     (tbl_wr_data)
    );

endmodule

/* dv/parser_tb.sv */
`timescale 1ns/1ps
`include "parser_settings.svh"

module parser_tb;

    localparam int NUM_ROWS  = 6;
    localparam int WD_CYCLES = NUM_ROWS * 40 + 200;
    localparam int OFF_4B    = `PARSER_NUM_CONT * 16;
    localparam int OFF_6B    = `PARSER_NUM_CONT * 48;
    localparam int HDR_BYTES = `PARSER_HDR_W / 8;
    localparam int K2        = 1;
    localparam int K4        = 2;
    localparam int K6        = 3;

    logic                        axis_clk;
    logic                        aresetn;
    logic [`PARSER_DATA_W-1:0]   s_tdata;
    logic                        s_tvalid;
    logic                        s_tlast;
    logic                        phv_valid;
    logic [`PARSER_PHV_W-1:0]    phv;
    logic [`PARSER_DATA_W-1:0]   c_s_tdata;
    logic                        c_s_tvalid;
    logic                        c_s_tlast;
    logic [`PARSER_DATA_W-1:0]   c_m_tdata;
    logic                        c_m_tvalid;
    logic                        c_m_tlast;

    // one row per packet with action 0 in the top 16 bits of row_entry
    int                          row_idx [NUM_ROWS];
    logic [`PARSER_ENTRY_W-1:0]  row_entry [NUM_ROWS];
    logic [`PARSER_DATA_W-1:0]   row_beat0 [NUM_ROWS];
    logic [`PARSER_DATA_W-1:0]   row_beat1 [NUM_ROWS];

    integer seed = 32'h054151d6;
    int     num_checks = 0;
    int     num_mismatch = 0;
    int     num_other = 0;

    parser_top #(
        .PARSER_ID (3'd3)
    ) i_dut (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .s_axis_tdata_i    (s_tdata),
        .s_axis_tvalid_i   (s_tvalid),
        .s_axis_tlast_i    (s_tlast),
        .phv_valid_o       (phv_valid),
        .phv_o             (phv),
        .c_s_axis_tdata_i  (c_s_tdata),
        .c_s_axis_tvalid_i (c_s_tvalid),
        .c_s_axis_tlast_i  (c_s_tlast),
        .c_m_axis_tdata_o  (c_m_tdata),
        .c_m_axis_tvalid_o (c_m_tvalid),
        .c_m_axis_tlast_o  (c_m_tlast)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge axis_clk);
        $display("run timed out after %0d cycles without finishing", WD_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [15:0] act(input int kind, input int cont, input int off);
        return {3'b000, off[6:0], cont[2:0], kind[1:0], 1'b1};
    endfunction

    function automatic logic [15:0] row_action(input int r, input int a);
        return row_entry[r][`PARSER_ENTRY_W-1-16*a -: 16];
    endfunction

    // fields land big endian with the lowest header byte on top of the container
    function automatic logic [`PARSER_PHV_W-1:0] model_phv(input int r);
        logic [`PARSER_HDR_W-1:0] win;
        logic [`PARSER_PHV_W-1:0] exp_phv;
        logic [15:0]              a_w;
        int                       nbytes;
        int                       base;
        int                       hb;
        win = {row_beat1[r], row_beat0[r]};
        exp_phv = '0;
        for (int a = 0; a < `PARSER_NUM_ACT; a++) begin
            a_w = row_action(r, a);
            nbytes = 0;
            if (a_w[0]) begin
                case (a_w[2:1])
                    K2: begin
                        nbytes = 2;
                        base = a_w[5:3] * 16;
                    end
                    K4: begin
                        nbytes = 4;
                        base = OFF_4B + a_w[5:3] * 32;
                    end
                    K6: begin
                        nbytes = 6;
                        base = OFF_6B + a_w[5:3] * 48;
                    end
                    default: nbytes = 0;
                endcase
            end
            for (int n = 0; n < nbytes; n++) begin
                hb = a_w[12:6] + n;
                exp_phv[base + (nbytes-1-n)*8 +: 8] = (hb < HDR_BYTES) ? win[hb*8 +: 8] : 8'h00;
            end
        end
        return exp_phv;
    endfunction

    task automatic check_value(input string name, input logic [`PARSER_PHV_W-1:0] expected,
                               input logic [`PARSER_PHV_W-1:0] actual);
        num_checks++;
        if (expected !== actual) begin
            num_mismatch++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic fill_random(output logic [`PARSER_DATA_W-1:0] beat);
        for (int w = 0; w < `PARSER_DATA_W/32; w++) begin
            beat[w*32 +: 32] = $random(seed);
        end
    endtask

    task automatic set_row(input int r, input int idx, input logic [`PARSER_ENTRY_W-1:0] entry);
        row_idx[r] = idx;
        row_entry[r] = entry;
        fill_random(row_beat0[r]);
        fill_random(row_beat1[r]);
        row_beat0[r][`PARSER_LOOKUP_LSB +: `PARSER_TBL_AW] = idx[`PARSER_TBL_AW-1:0];
    endtask

    task automatic build_table();
        // fields at 124 and 127 run past the window
        set_row(0, 5, {act(K2, 0, 0), act(K4, 1, 10), act(K6, 2, 20), act(K2, 3, 64),
                       act(K4, 4, 100), act(K6, 5, 124), act(K2, 7, 127), 16'h0000});
        // two writers each on 4B container 2 and 2B container 5 plus one invalid action
        set_row(1, 6, {act(K4, 2, 8), act(K4, 2, 40), act(K6, 0, 126), 16'hFFFE,
                       act(K2, 5, 70), act(K2, 5, 71), act(K6, 7, 60), act(K4, 7, 0)});
        set_row(2, 7, {act(K6, 0, 0), act(K6, 1, 16), act(K6, 2, 32), act(K6, 3, 48),
                       act(K6, 4, 64), act(K6, 5, 80), act(K6, 6, 96), act(K6, 7, 112)});
        set_row(3, 12, {act(K2, 0, 90), act(K4, 0, 94), act(K6, 0, 98), act(K2, 6, 102),
                        act(K4, 6, 106), act(K6, 6, 110), act(K2, 1, 114), act(K4, 1, 118)});
        // sparse entry right after a full one
        set_row(4, 13, {16'h0000, act(K4, 3, 64), 16'h0000, 16'h0000,
                        act(K6, 6, 1), 16'h0000, 16'h0000, 16'h0000});
        set_row(5, 5, row_entry[0]);
    endtask

    task automatic forward_beat(input string name, input logic [7:0] mod_id,
                                input logic [15:0] flag);
        logic [`PARSER_DATA_W-1:0] beat;
        fill_random(beat);
        beat[`CTRL_MODID_LSB +: 8] = mod_id;
        beat[`CTRL_FLAG_LSB +: 16] = flag;
        @(posedge axis_clk);
        #2;
        c_s_tdata = beat;
        c_s_tvalid = 1'b1;
        c_s_tlast = 1'b1;
        @(posedge axis_clk);
        #1;
        check_value({name, "_tdata"}, beat, c_m_tdata);
        check_value({name, "_tvalid"}, 1, c_m_tvalid);
        check_value({name, "_tlast"}, 1, c_m_tlast);
        #1;
        c_s_tvalid = 1'b0;
        c_s_tlast = 1'b0;
        @(posedge axis_clk);
        #1;
        check_value({name, "_idle"}, 0, c_m_tvalid);
    endtask

    task automatic write_entries(input logic [7:0] mod_id, input int first_row,
                                 input int count);
        logic [`PARSER_DATA_W-1:0] beat;
        logic [15:0]               a_w;
        beat = '0;
        beat[`CTRL_MODID_LSB +: 8] = mod_id;
        beat[`CTRL_FLAG_LSB +: 16] = `CTRL_WRITE_FLAG;
        beat[`CTRL_INDEX_LSB +: `PARSER_TBL_AW] = row_idx[first_row][`PARSER_TBL_AW-1:0];
        @(posedge axis_clk);
        #2;
        c_s_tdata = beat;
        c_s_tvalid = 1'b1;
        c_s_tlast = 1'b0;
        for (int k = 0; k <= count; k++) begin
            @(posedge axis_clk);
            #1;
            check_value("cfg_not_forwarded", 0, c_m_tvalid);
            #1;
            if (k < count) begin
                // action i sits in control bytes 2i and 2i+1 with the high byte first
                beat = '0;
                for (int a = 0; a < `PARSER_NUM_ACT; a++) begin
                    a_w = row_action(first_row + k, a);
                    beat[16*a +: 8] = a_w[15:8];
                    beat[16*a + 8 +: 8] = a_w[7:0];
                end
                c_s_tdata = beat;
                c_s_tlast = (k == count - 1);
            end else begin
                c_s_tvalid = 1'b0;
                c_s_tlast = 1'b0;
            end
        end
        @(posedge axis_clk);
        #1;
        check_value("cfg_not_forwarded", 0, c_m_tvalid);
    endtask

    task automatic run_packet(input int r);
        logic [`PARSER_PHV_W-1:0] expected;
        int                       cycles;
        expected = model_phv(r);
        @(posedge axis_clk);
        #2;
        s_tdata = row_beat0[r];
        s_tvalid = 1'b1;
        s_tlast = 1'b0;
        @(posedge axis_clk);
        #2;
        s_tdata = row_beat1[r];
        s_tlast = 1'b1;
        @(posedge axis_clk);
        #2;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tdata = '0;
        // edge of the first beat is cycle 0
        cycles = 1;
        while (!phv_valid && cycles < 10) begin
            @(posedge axis_clk);
            #1;
            cycles++;
        end
        if (!phv_valid) begin
            $display("row %0d: phv_valid_o never rose within %0d cycles of the first beat",
                     r, cycles);
            num_other++;
        end else begin
            check_value($sformatf("row%0d_latency", r), 3, cycles);
            check_value($sformatf("row%0d_phv", r), expected, phv);
            @(posedge axis_clk);
            #1;
            check_value($sformatf("row%0d_valid_width", r), 0, phv_valid);
            check_value($sformatf("row%0d_phv_hold", r), expected, phv);
        end
        repeat (2) @(posedge axis_clk);
    endtask

    initial begin
        aresetn = 1'b0;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        c_s_tdata = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast = 1'b0;
        build_table();
        repeat (16) @(posedge axis_clk);
        #2;
        aresetn = 1'b1;
        @(posedge axis_clk);
        #1;
        check_value("reset_phv_valid", 0, phv_valid);
        check_value("reset_ctrl_tvalid", 0, c_m_tvalid);
        forward_beat("fwd_wrong_id", 8'h02, `CTRL_WRITE_FLAG);
        forward_beat("fwd_wrong_flag", 8'h03, 16'hF1F3);
        write_entries(8'h03, 0, 3);
        // upper module id bits are ignored
        write_entries(8'hFB, 3, 2);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_packet(r);
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 num_checks, num_mismatch, num_other);
        if (num_mismatch == 0 && num_other == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/parser_pkg.sv
source/ctrl_pkg.sv
source/parse_fsm.sv
source/header_capture.sv
source/parse_action_table.sv
source/field_extractor.sv
source/phv_assembler.sv
source/config_writer.sv
source/parser_top.sv
dv/parser_tb.sv
